// File: logic/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

`define MIPS_WORD_W      32
`define MIPS_REG_ADDR_W  5
`define MIPS_LINK_REG    31

`define MIPS_OP_SPECIAL  6'b000000
`define MIPS_OP_REGIMM   6'b000001
`define MIPS_OP_ORI      6'b001101
`define MIPS_OP_ANDI     6'b001100
`define MIPS_OP_XORI     6'b001110
`define MIPS_OP_LUI      6'b001111
`define MIPS_OP_ADDI     6'b001000
`define MIPS_OP_ADDIU    6'b001001
`define MIPS_OP_J        6'b000010
`define MIPS_OP_JAL      6'b000011
`define MIPS_OP_BEQ      6'b000100
`define MIPS_OP_BNE      6'b000101
`define MIPS_OP_BLEZ     6'b000110
`define MIPS_OP_BGTZ     6'b000111

`define MIPS_FN_OR       6'b100101
`define MIPS_FN_AND      6'b100100
`define MIPS_FN_XOR      6'b100110
`define MIPS_FN_SLL      6'b000000
`define MIPS_FN_SRL      6'b000010
`define MIPS_FN_SRA      6'b000011
`define MIPS_FN_SLLV     6'b000100
`define MIPS_FN_SRLV     6'b000110
`define MIPS_FN_SRAV     6'b000111
`define MIPS_FN_SLT      6'b101010
`define MIPS_FN_ADD      6'b100000
`define MIPS_FN_ADDU     6'b100001
`define MIPS_FN_SUB      6'b100010
`define MIPS_FN_JR       6'b001000
`define MIPS_FN_JALR     6'b001001

`define MIPS_RT_BLTZ     5'b00000
`define MIPS_RT_BGEZ     5'b00001

`endif

// File: logic/mips_pkg.sv
`include "mips_config.svh"

package mips_pkg;

  typedef logic [`MIPS_WORD_W-1:0]     word_t;
  typedef logic [`MIPS_REG_ADDR_W-1:0] reg_addr_t;

  typedef struct packed {
    logic [5:0] op;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fields_t;

  typedef struct packed {
    logic [5:0]  op;
    reg_addr_t   rs;
    reg_addr_t   rt;
    logic [15:0] imm16;
  } i_fields_t;

  typedef struct packed {
    logic [5:0]  op;
    logic [25:0] target26;
  } j_fields_t;

  // one instruction word, viewed per format
  typedef union packed {
    r_fields_t r;
    i_fields_t i;
    j_fields_t j;
    word_t     raw;
  } inst_word_u;

  typedef enum logic [4:0] {
    ALU_NOP, ALU_OR, ALU_AND, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT,
    ALU_ADD, ALU_ADDU, ALU_SUB, ALU_ADDI, ALU_ADDIU, ALU_J, ALU_JAL, ALU_JR,
    ALU_JALR, ALU_BEQ, ALU_BNE, ALU_BGTZ, ALU_BLEZ, ALU_BGEZ, ALU_BLTZ
  } alu_op_e;

  typedef enum logic [2:0] {
    SEL_NOP, SEL_LOGIC, SEL_SHIFT, SEL_ARITH, SEL_JUMP_BRANCH
  } alu_sel_e;

  typedef enum logic [3:0] {
    BR_NONE, BR_JUMP_IMM, BR_JUMP_REG, BR_EQ, BR_NE, BR_GTZ, BR_LEZ, BR_GEZ, BR_LTZ
  } branch_kind_e;

endpackage

// File: logic/inst_decoder.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module inst_decoder import mips_pkg::*; (
  input  logic         reset_i,
  input  inst_word_u   inst_i,
  output alu_op_e      aluop_o,
  output alu_sel_e     alusel_o,
  output reg_addr_t    wd_o,
  output logic         wreg_o,
  output logic         reg1_read_o,
  output logic         reg2_read_o,
  output reg_addr_t    reg1_addr_o,
  output reg_addr_t    reg2_addr_o,
  output word_t        imm_o,
  output branch_kind_e branch_kind_o,
  output logic         link_o,
  output logic         inst_valid_o
);

  logic shift_imm; // sll/srl/sra use shamt as operand 1

  always_comb begin
    aluop_o       = ALU_NOP;
    alusel_o      = SEL_NOP;
    wd_o          = inst_i.r.rd;
    wreg_o        = 1'b0;
    reg1_read_o   = 1'b0;
    reg2_read_o   = 1'b0;
    reg1_addr_o   = inst_i.r.rs;
    reg2_addr_o   = inst_i.r.rt;
    imm_o         = '0;
    branch_kind_o = BR_NONE;
    link_o        = 1'b0;
    inst_valid_o  = 1'b0;
    shift_imm     = 1'b0;
    if (reset_i) begin
      wd_o         = '0;
      reg1_addr_o  = '0;
      reg2_addr_o  = '0;
      inst_valid_o = 1'b1; // bubble, not an illegal word
    end else begin
      case (inst_i.r.op)
        `MIPS_OP_SPECIAL: begin
          case (inst_i.r.funct)
            `MIPS_FN_OR:   alusel_o = SEL_LOGIC;
            `MIPS_FN_AND:  alusel_o = SEL_LOGIC;
            `MIPS_FN_XOR:  alusel_o = SEL_LOGIC;
            `MIPS_FN_SLT:  alusel_o = SEL_ARITH;
            `MIPS_FN_ADD:  alusel_o = SEL_ARITH;
            `MIPS_FN_ADDU: alusel_o = SEL_ARITH;
            `MIPS_FN_SUB:  alusel_o = SEL_ARITH;
            `MIPS_FN_SLL, `MIPS_FN_SRL, `MIPS_FN_SRA,
            `MIPS_FN_SLLV, `MIPS_FN_SRLV, `MIPS_FN_SRAV: begin
              shift_imm = !inst_i.r.funct[2];
              if (!shift_imm || inst_i.raw[31:21] == '0) begin
                alusel_o = SEL_SHIFT;
                imm_o    = shift_imm ? word_t'(inst_i.r.shamt) : '0;
              end
            end
            `MIPS_FN_JR: begin
              alusel_o      = SEL_JUMP_BRANCH;
              branch_kind_o = BR_JUMP_REG;
            end
            `MIPS_FN_JALR: begin
              alusel_o      = SEL_JUMP_BRANCH;
              branch_kind_o = BR_JUMP_REG;
              link_o        = 1'b1; // link into rd
            end
            default: ;
          endcase
          case (inst_i.r.funct)
            `MIPS_FN_OR:                 aluop_o = ALU_OR;
            `MIPS_FN_AND:                aluop_o = ALU_AND;
            `MIPS_FN_XOR:                aluop_o = ALU_XOR;
            `MIPS_FN_SLT:                aluop_o = ALU_SLT;
            `MIPS_FN_ADD:                aluop_o = ALU_ADD;
            `MIPS_FN_ADDU:               aluop_o = ALU_ADDU;
            `MIPS_FN_SUB:                aluop_o = ALU_SUB;
            `MIPS_FN_SLL, `MIPS_FN_SLLV: aluop_o = ALU_SLL;
            `MIPS_FN_SRL, `MIPS_FN_SRLV: aluop_o = ALU_SRL;
            `MIPS_FN_SRA, `MIPS_FN_SRAV: aluop_o = ALU_SRA;
            `MIPS_FN_JR:                 aluop_o = ALU_JR;
            `MIPS_FN_JALR:               aluop_o = ALU_JALR;
            default: ;
          endcase
          if (alusel_o != SEL_NOP) begin
            inst_valid_o = 1'b1;
            wreg_o       = (inst_i.r.funct != `MIPS_FN_JR);
            reg1_read_o  = !shift_imm;
            reg2_read_o  = (alusel_o != SEL_JUMP_BRANCH);
          end else begin
            aluop_o = ALU_NOP; // illegal shift form
          end
        end
        `MIPS_OP_ORI, `MIPS_OP_ANDI, `MIPS_OP_XORI,
        `MIPS_OP_LUI, `MIPS_OP_ADDI, `MIPS_OP_ADDIU: begin
          wd_o         = inst_i.i.rt;
          wreg_o       = 1'b1;
          reg1_read_o  = 1'b1;
          inst_valid_o = 1'b1;
          alusel_o     = SEL_LOGIC;
          aluop_o      = ALU_OR; // ori, lui
          imm_o        = {16'h0, inst_i.i.imm16};
          case (inst_i.i.op)
            `MIPS_OP_ANDI: aluop_o = ALU_AND;
            `MIPS_OP_XORI: aluop_o = ALU_XOR;
            `MIPS_OP_LUI:  imm_o = {inst_i.i.imm16, 16'h0};
            `MIPS_OP_ADDI, `MIPS_OP_ADDIU: begin
              alusel_o = SEL_ARITH;
              aluop_o  = (inst_i.i.op == `MIPS_OP_ADDI) ? ALU_ADDI : ALU_ADDIU;
              imm_o    = {{16{inst_i.i.imm16[15]}}, inst_i.i.imm16};
            end
            default: ;
          endcase
        end
        `MIPS_OP_J, `MIPS_OP_JAL: begin
          alusel_o      = SEL_JUMP_BRANCH;
          branch_kind_o = BR_JUMP_IMM;
          inst_valid_o  = 1'b1;
          aluop_o       = ALU_J;
          if (inst_i.j.op == `MIPS_OP_JAL) begin
            aluop_o = ALU_JAL;
            wreg_o  = 1'b1;
            wd_o    = reg_addr_t'(`MIPS_LINK_REG);
            link_o  = 1'b1;
          end
        end
        `MIPS_OP_BEQ, `MIPS_OP_BNE, `MIPS_OP_BLEZ, `MIPS_OP_BGTZ: begin
          alusel_o     = SEL_JUMP_BRANCH;
          reg1_read_o  = 1'b1;
          inst_valid_o = 1'b1;
          case (inst_i.i.op)
            `MIPS_OP_BEQ: begin
              aluop_o       = ALU_BEQ;
              branch_kind_o = BR_EQ;
              reg2_read_o   = 1'b1;
            end
            `MIPS_OP_BNE: begin
              aluop_o       = ALU_BNE;
              branch_kind_o = BR_NE;
              reg2_read_o   = 1'b1;
            end
            `MIPS_OP_BLEZ: begin
              aluop_o       = ALU_BLEZ;
              branch_kind_o = BR_LEZ;
            end
            default: begin
              aluop_o       = ALU_BGTZ;
              branch_kind_o = BR_GTZ;
            end
          endcase
        end
        `MIPS_OP_REGIMM: begin
          case (inst_i.i.rt)
            `MIPS_RT_BGEZ: begin
              aluop_o       = ALU_BGEZ;
              branch_kind_o = BR_GEZ;
            end
            `MIPS_RT_BLTZ: begin
              aluop_o       = ALU_BLTZ;
              branch_kind_o = BR_LTZ;
            end
            default: ;
          endcase
          if (branch_kind_o != BR_NONE) begin
            alusel_o     = SEL_JUMP_BRANCH;
            reg1_read_o  = 1'b1;
            inst_valid_o = 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  // an unrecognised word must never reach write-back
  always_comb begin
    assert (inst_valid_o || !wreg_o)
      else $error("inst_decoder: write enable on invalid word %h", inst_i.raw);
  end

endmodule

// File: logic/operand_select.sv
`timescale 1ns/1ps

module operand_select import mips_pkg::*; (
  input  logic      reset_i,
  input  logic      read_i,
  input  reg_addr_t addr_i,
  input  word_t     rf_data_i,
  input  word_t     imm_i,
  input  logic      ex_wreg_i,
  input  reg_addr_t ex_wd_i,
  input  word_t     ex_wdata_i,
  input  logic      mem_wreg_i,
  input  reg_addr_t mem_wd_i,
  input  word_t     mem_wdata_i,
  output word_t     operand_o
);

  logic ex_hit;
  logic mem_hit;

  assign ex_hit  = read_i && ex_wreg_i && (ex_wd_i == addr_i);
  assign mem_hit = read_i && mem_wreg_i && (mem_wd_i == addr_i);

  always_comb begin
    if (reset_i) begin
      operand_o = '0;
    end else if (ex_hit) begin
      operand_o = ex_wdata_i; // youngest result wins
    end else if (mem_hit) begin
      operand_o = mem_wdata_i;
    end else if (read_i) begin
      operand_o = rf_data_i;
    end else begin
      operand_o = imm_i;
    end
  end

  // forwarding must not leak into an immediate operand
  always_comb begin
    assert (reset_i || read_i || operand_o == imm_i)
      else $error("operand_select: non-immediate operand with read disabled");
  end

endmodule

// File: logic/branch_unit.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module branch_unit import mips_pkg::*; (
  input  logic         clk,
  input  logic         reset_i,
  input  word_t        pc_i,
  input  inst_word_u   inst_i,
  input  branch_kind_e branch_kind_i,
  input  logic         link_i,
  input  word_t        reg1_i,
  input  word_t        reg2_i,
  output logic         branch_flag_o,
  output word_t        branch_target_o,
  output word_t        link_addr_o,
  output logic         next_inst_in_delayslot_o,
  output logic         is_in_delayslot_o
);

  word_t pc_plus_4;
  word_t pc_plus_8;
  word_t branch_offset;
  logic  cond_met;

  assign pc_plus_4     = pc_i + word_t'(4);
  assign pc_plus_8     = pc_i + word_t'(8);
  assign branch_offset = {{14{inst_i.i.imm16[15]}}, inst_i.i.imm16, 2'b00};

  always_comb begin
    case (branch_kind_i)
      BR_EQ:   cond_met = (reg1_i == reg2_i);
      BR_NE:   cond_met = (reg1_i != reg2_i);
      BR_GTZ:  cond_met = !reg1_i[`MIPS_WORD_W-1] && (reg1_i != '0);
      BR_LEZ:  cond_met = reg1_i[`MIPS_WORD_W-1] || (reg1_i == '0);
      BR_GEZ:  cond_met = !reg1_i[`MIPS_WORD_W-1];
      BR_LTZ:  cond_met = reg1_i[`MIPS_WORD_W-1];
      default: cond_met = 1'b0; // jumps and none
    endcase
  end

  always_comb begin
    branch_flag_o   = 1'b0;
    branch_target_o = '0;
    if (branch_kind_i == BR_JUMP_IMM) begin
      branch_flag_o   = 1'b1;
      branch_target_o = {pc_plus_4[`MIPS_WORD_W-1 -: 4], inst_i.j.target26, 2'b00};
    end else if (branch_kind_i == BR_JUMP_REG) begin
      branch_flag_o   = 1'b1;
      branch_target_o = reg1_i;
    end else if (cond_met) begin
      branch_flag_o   = 1'b1;
      branch_target_o = pc_plus_4 + branch_offset;
    end
  end

  assign link_addr_o              = link_i ? pc_plus_8 : '0; // skip the delay slot
  assign next_inst_in_delayslot_o = branch_flag_o;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      is_in_delayslot_o <= 1'b0;
    end else begin
      is_in_delayslot_o <= next_inst_in_delayslot_o;
    end
  end

  // a taken branch puts the following instruction in the delay slot
  assert property (@(posedge clk) disable iff (reset_i)
    branch_flag_o |=> is_in_delayslot_o);

  assert property (@(posedge clk) reset_i |=> !is_in_delayslot_o);

endmodule

// File: logic/id_stage.sv
`timescale 1ns/1ps

module id_stage import mips_pkg::*; (
  input  logic       clk,
  input  logic       reset_i,
  input  word_t      pc_i,
  input  inst_word_u inst_i,
  input  word_t      reg1_data_i,
  input  word_t      reg2_data_i,
  input  logic       ex_wreg_i,
  input  reg_addr_t  ex_wd_i,
  input  word_t      ex_wdata_i,
  input  logic       mem_wreg_i,
  input  reg_addr_t  mem_wd_i,
  input  word_t      mem_wdata_i,
  output logic       reg1_read_o,
  output logic       reg2_read_o,
  output reg_addr_t  reg1_addr_o,
  output reg_addr_t  reg2_addr_o,
  output alu_op_e    aluop_o,
  output alu_sel_e   alusel_o,
  output word_t      reg1_o,
  output word_t      reg2_o,
  output reg_addr_t  wd_o,
  output logic       wreg_o,
  output logic       inst_valid_o,
  output logic       branch_flag_o,
  output word_t      branch_target_address_o,
  output word_t      link_addr_o,
  output logic       next_inst_in_delayslot_o,
  output logic       is_in_delayslot_o
);

  word_t        imm;
  branch_kind_e branch_kind;
  logic         link;

  inst_decoder u_decoder (
    .reset_i       (reset_i),
    .inst_i        (inst_i),
    .aluop_o       (aluop_o),
    .alusel_o      (alusel_o),
    .wd_o          (wd_o),
    .wreg_o        (wreg_o),
    .reg1_read_o   (reg1_read_o),
    .reg2_read_o   (reg2_read_o),
    .reg1_addr_o   (reg1_addr_o),
    .reg2_addr_o   (reg2_addr_o),
    .imm_o         (imm),
    .branch_kind_o (branch_kind),
    .link_o        (link),
    .inst_valid_o  (inst_valid_o)
  );

  operand_select u_operand1 (
    .reset_i     (reset_i),
    .read_i      (reg1_read_o),
    .addr_i      (reg1_addr_o),
    .rf_data_i   (reg1_data_i),
    .imm_i       (imm),
    .ex_wreg_i   (ex_wreg_i),
    .ex_wd_i     (ex_wd_i),
    .ex_wdata_i  (ex_wdata_i),
    .mem_wreg_i  (mem_wreg_i),
    .mem_wd_i    (mem_wd_i),
    .mem_wdata_i (mem_wdata_i),
    .operand_o   (reg1_o)
  );

  operand_select u_operand2 (
    .reset_i     (reset_i),
    .read_i      (reg2_read_o),
    .addr_i      (reg2_addr_o),
    .rf_data_i   (reg2_data_i),
    .imm_i       (imm),
    .ex_wreg_i   (ex_wreg_i),
    .ex_wd_i     (ex_wd_i),
    .ex_wdata_i  (ex_wdata_i),
    .mem_wreg_i  (mem_wreg_i),
    .mem_wd_i    (mem_wd_i),
    .mem_wdata_i (mem_wdata_i),
    .operand_o   (reg2_o)
  );

  branch_unit u_branch (
    .clk                      (clk),
    .reset_i                  (reset_i),
    .pc_i                     (pc_i),
    .inst_i                   (inst_i),
    .branch_kind_i            (branch_kind),
    .link_i                   (link),
    .reg1_i                   (reg1_o),
    .reg2_i                   (reg2_o),
    .branch_flag_o            (branch_flag_o),
    .branch_target_o          (branch_target_address_o),
    .link_addr_o              (link_addr_o),
    .next_inst_in_delayslot_o (next_inst_in_delayslot_o),
    .is_in_delayslot_o        (is_in_delayslot_o)
  );

endmodule

// File: test/id_stage_tb.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module id_stage_tb import mips_pkg::*;;

  localparam int TIMEOUT_CYCLES = 2000;

  logic       clk;
  logic       reset_i;
  word_t      pc_i;
  inst_word_u inst_i;
  word_t      reg1_data_i, reg2_data_i;
  logic       ex_wreg_i, mem_wreg_i;
  reg_addr_t  ex_wd_i, mem_wd_i;
  word_t      ex_wdata_i, mem_wdata_i;
  logic       reg1_read_o, reg2_read_o, wreg_o, inst_valid_o;
  reg_addr_t  reg1_addr_o, reg2_addr_o, wd_o;
  alu_op_e    aluop_o;
  alu_sel_e   alusel_o;
  word_t      reg1_o, reg2_o, branch_target_address_o, link_addr_o;
  logic       branch_flag_o, next_inst_in_delayslot_o, is_in_delayslot_o;

  int seed = 32'h72c33b8e;
  int errors = 0;
  int checks = 0;
  int test_start;

  id_stage DUT (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    #(TIMEOUT_CYCLES * 8);
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("test failed");
    $finish;
  end

  function automatic word_t rnd();
    rnd = $random(seed);
  endfunction

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    $display("%s done, %0d errors", name, errors - test_start);
    test_start = errors;
  endtask

  // drive one word a little after the edge, then wait until just before the next edge
  task automatic drive(input word_t word, input word_t r1, input word_t r2);
    @(posedge clk);
    #1;
    inst_i.raw  = word;
    reg1_data_i = r1;
    reg2_data_i = r2;
    #6;
  endtask

  // same slot timing, with the write-back ports of the execute and memory stages
  task automatic drive_fwd(input logic ex_en, input reg_addr_t ex_addr, input logic mem_en,
                           input reg_addr_t mem_addr, input word_t word);
    @(posedge clk);
    #1;
    ex_wreg_i  = ex_en;
    ex_wd_i    = ex_addr;
    mem_wreg_i = mem_en;
    mem_wd_i   = mem_addr;
    inst_i.raw = word;
    #6;
  endtask

  task automatic check_no_branch();
    check_val("branch_flag", 32'(branch_flag_o), 0);
    check_val("branch_target", branch_target_address_o, 0);
    check_val("link_addr", link_addr_o, 0);
    check_val("next_in_delayslot", 32'(next_inst_in_delayslot_o), 0);
  endtask

  task automatic test_reset();
    repeat (7) @(posedge clk);
    #1;
    inst_i.raw = {`MIPS_OP_JAL, 26'h155aa};
    #6;
    check_val("reset aluop", 32'(aluop_o), 32'(ALU_NOP));
    check_val("reset alusel", 32'(alusel_o), 32'(SEL_NOP));
    check_val("reset wreg", 32'(wreg_o), 0);
    check_val("reset wd", 32'(wd_o), 0);
    check_val("reset reads", {30'h0, reg1_read_o, reg2_read_o}, 0);
    check_val("reset addrs", {reg1_addr_o, reg2_addr_o}, 0);
    check_val("reset reg1", reg1_o, 0);
    check_val("reset reg2", reg2_o, 0);
    check_val("reset valid", 32'(inst_valid_o), 1);
    check_val("reset delayslot", 32'(is_in_delayslot_o), 0);
    check_no_branch();
    @(posedge clk);
    #1;
    reset_i    = 1'b0;
    inst_i.raw = '0; // sll r0, r0, 0
    #6;
    check_val("delayslot after reset", 32'(is_in_delayslot_o), 0);
    end_test("reset");
  endtask

  task automatic check_r(input logic [5:0] funct, input alu_op_e op, input alu_sel_e sel,
                         input bit imm_shift);
    word_t d1, d2, w;
    reg_addr_t rs, rt, rd;
    logic [4:0] shamt;
    w = rnd();
    rs = imm_shift ? 5'd0 : w[4:0];
    rt = w[9:5];
    rd = w[14:10];
    shamt = imm_shift ? w[19:15] : 5'd0;
    d1 = rnd();
    d2 = rnd();
    drive({`MIPS_OP_SPECIAL, rs, rt, rd, shamt, funct}, d1, d2);
    check_val("aluop", 32'(aluop_o), 32'(op));
    check_val("alusel", 32'(alusel_o), 32'(sel));
    check_val("wd", 32'(wd_o), 32'(rd));
    check_val("wreg", 32'(wreg_o), 1);
    check_val("reg1_read", 32'(reg1_read_o), 32'(!imm_shift));
    check_val("reg2_read", 32'(reg2_read_o), 1);
    check_val("reg1_addr", 32'(reg1_addr_o), 32'(rs));
    check_val("reg2_addr", 32'(reg2_addr_o), 32'(rt));
    check_val("reg1", reg1_o, imm_shift ? 32'(shamt) : d1);
    check_val("reg2", reg2_o, d2);
    check_no_branch();
  endtask

  // ext selects zero-extend (0), sign-extend (1) or upper half (2)
  task automatic check_i(input logic [5:0] opc, input alu_op_e op, input alu_sel_e sel,
                         input int ext);
    word_t d1, w, imm;
    w = rnd();
    d1 = rnd();
    if (ext == 0) imm = {16'h0, w[15:0]};
    else if (ext == 1) imm = {{16{w[15]}}, w[15:0]};
    else imm = {w[15:0], 16'h0};
    drive({opc, w[20:16], w[25:21], w[15:0]}, d1, rnd());
    check_val("aluop", 32'(aluop_o), 32'(op));
    check_val("alusel", 32'(alusel_o), 32'(sel));
    check_val("wd", 32'(wd_o), 32'(w[25:21]));
    check_val("wreg", 32'(wreg_o), 1);
    check_val("reads", {30'h0, reg1_read_o, reg2_read_o}, 2);
    check_val("reg1_addr", 32'(reg1_addr_o), 32'(w[20:16]));
    check_val("reg2_addr", 32'(reg2_addr_o), 32'(w[25:21]));
    check_val("reg1", reg1_o, d1);
    check_val("reg2 imm", reg2_o, imm);
  endtask

  task automatic test_alu_decode();
    check_r(`MIPS_FN_OR, ALU_OR, SEL_LOGIC, 0);
    check_r(`MIPS_FN_AND, ALU_AND, SEL_LOGIC, 0);
    check_r(`MIPS_FN_XOR, ALU_XOR, SEL_LOGIC, 0);
    check_r(`MIPS_FN_SLT, ALU_SLT, SEL_ARITH, 0);
    check_r(`MIPS_FN_ADD, ALU_ADD, SEL_ARITH, 0);
    check_r(`MIPS_FN_ADDU, ALU_ADDU, SEL_ARITH, 0);
    check_r(`MIPS_FN_SUB, ALU_SUB, SEL_ARITH, 0);
    check_r(`MIPS_FN_SLLV, ALU_SLL, SEL_SHIFT, 0);
    check_r(`MIPS_FN_SRLV, ALU_SRL, SEL_SHIFT, 0);
    check_r(`MIPS_FN_SRAV, ALU_SRA, SEL_SHIFT, 0);
    check_r(`MIPS_FN_SLL, ALU_SLL, SEL_SHIFT, 1);
    check_r(`MIPS_FN_SRL, ALU_SRL, SEL_SHIFT, 1);
    check_r(`MIPS_FN_SRA, ALU_SRA, SEL_SHIFT, 1);
    check_i(`MIPS_OP_ORI, ALU_OR, SEL_LOGIC, 0);
    check_i(`MIPS_OP_ANDI, ALU_AND, SEL_LOGIC, 0);
    check_i(`MIPS_OP_XORI, ALU_XOR, SEL_LOGIC, 0);
    check_i(`MIPS_OP_LUI, ALU_OR, SEL_LOGIC, 2);
    check_i(`MIPS_OP_ADDI, ALU_ADDI, SEL_ARITH, 1);
    check_i(`MIPS_OP_ADDIU, ALU_ADDIU, SEL_ARITH, 1);
    end_test("alu decode");
  endtask

  task automatic test_forwarding();
    word_t d1, d2, exd, memd, addu_w;
    d1 = rnd();
    d2 = rnd();
    exd = rnd();
    memd = rnd();
    addu_w = {`MIPS_OP_SPECIAL, 5'd7, 5'd9, 5'd3, 5'd0, `MIPS_FN_ADDU}; // addu r3, r7, r9
    @(posedge clk);
    #1;
    ex_wdata_i  = exd;
    mem_wdata_i = memd;
    reg1_data_i = d1;
    reg2_data_i = d2;
    drive_fwd(1'b1, 5'd7, 1'b1, 5'd7, addu_w);
    check_val("ex beats mem", reg1_o, exd);
    check_val("no match rf", reg2_o, d2);
    drive_fwd(1'b0, 5'd7, 1'b1, 5'd7, addu_w);
    check_val("mem when ex off", reg1_o, memd);
    drive_fwd(1'b1, 5'd8, 1'b1, 5'd9, addu_w);
    check_val("ex addr mismatch", reg1_o, d1);
    check_val("mem on reg2", reg2_o, memd);
    drive_fwd(1'b0, 5'd8, 1'b0, 5'd9, addu_w);
    check_val("mem off falls to rf", reg2_o, d2);
    end_test("forwarding");
  endtask

  task automatic check_branch(input word_t word, input word_t r1, input word_t r2,
                              input bit taken);
    word_t target;
    int offset;
    offset = $signed(word[15:0]);
    target = pc_i + 32'd4 + word_t'(offset * 4);
    drive(word, r1, r2);
    if (taken) begin
      check_val("branch_flag", 32'(branch_flag_o), 1);
      check_val("branch_target", branch_target_address_o, target);
      check_val("next_in_delayslot", 32'(next_inst_in_delayslot_o), 1);
    end else begin
      check_no_branch();
    end
    drive('0, r1, r2);
    check_val("is_in_delayslot", 32'(is_in_delayslot_o), 32'(taken));
  endtask

  task automatic test_branches();
    word_t v;
    logic [15:0] off;
    v = rnd();
    off = v[15:0];
    @(posedge clk);
    #1;
    pc_i = {v[31:2], 2'b00};
    check_branch({`MIPS_OP_BEQ, 5'd1, 5'd2, off}, v, v, 1);
    check_branch({`MIPS_OP_BEQ, 5'd1, 5'd2, off}, v, ~v, 0);
    check_branch({`MIPS_OP_BNE, 5'd1, 5'd2, off}, v, ~v, 1);
    check_branch({`MIPS_OP_BNE, 5'd1, 5'd2, off}, 0, 0, 0);
    check_branch({`MIPS_OP_BGTZ, 5'd1, 5'd0, off}, 32'd5, 0, 1);
    check_branch({`MIPS_OP_BGTZ, 5'd1, 5'd0, off}, 0, 0, 0);
    check_branch({`MIPS_OP_BGTZ, 5'd1, 5'd0, off}, 32'hffff_fff0, 0, 0);
    check_branch({`MIPS_OP_BLEZ, 5'd1, 5'd0, off}, 0, 0, 1);
    check_branch({`MIPS_OP_BLEZ, 5'd1, 5'd0, off}, 32'h8000_0000, 0, 1);
    check_branch({`MIPS_OP_BLEZ, 5'd1, 5'd0, off}, 32'd1, 0, 0);
    check_branch({`MIPS_OP_REGIMM, 5'd1, `MIPS_RT_BGEZ, off}, 0, 0, 1);
    check_branch({`MIPS_OP_REGIMM, 5'd1, `MIPS_RT_BGEZ, off}, 32'hffff_ffff, 0, 0);
    check_branch({`MIPS_OP_REGIMM, 5'd1, `MIPS_RT_BLTZ, off}, 32'hffff_ffff, 0, 1);
    check_branch({`MIPS_OP_REGIMM, 5'd1, `MIPS_RT_BLTZ, off}, 0, 0, 0);
    end_test("branches");
  endtask

  task automatic check_jump(input word_t word, input word_t r1, input word_t target,
                            input bit link, input bit wreg, input reg_addr_t wd);
    drive(word, r1, rnd());
    check_val("jump flag", 32'(branch_flag_o), 1);
    check_val("jump target", branch_target_address_o, target);
    check_val("jump delayslot", 32'(next_inst_in_delayslot_o), 1);
    check_val("link_addr", link_addr_o, link ? pc_i + 32'd8 : 0);
    check_val("jump wreg", 32'(wreg_o), 32'(wreg));
    if (wreg) check_val("jump wd", 32'(wd_o), 32'(wd));
  endtask

  task automatic test_jumps();
    word_t v, r1;
    logic [3:0] region;
    v = rnd();
    r1 = rnd();
    @(posedge clk);
    #1;
    pc_i = {v[31:2], 2'b00};
    region = pc_i[31:28] + 4'(pc_i[27:0] > 28'hffffffb); // top bits of pc+4
    check_jump({`MIPS_OP_J, v[25:0]}, r1, {region, v[25:0], 2'b00}, 0, 0, 0);
    check_jump({`MIPS_OP_JAL, v[25:0]}, r1, {region, v[25:0], 2'b00},
               1, 1, 5'(`MIPS_LINK_REG));
    check_jump({`MIPS_OP_SPECIAL, 5'd4, 5'd0, 5'd0, 5'd0, `MIPS_FN_JR}, r1, r1, 0, 0, 0);
    check_jump({`MIPS_OP_SPECIAL, 5'd4, 5'd0, 5'd12, 5'd0, `MIPS_FN_JALR}, r1, r1,
               1, 1, 5'd12);
    end_test("jumps");
  endtask

  task automatic check_invalid(input word_t word);
    drive(word, rnd(), rnd());
    check_val("inst_valid", 32'(inst_valid_o), 0);
    check_val("invalid wreg", 32'(wreg_o), 0);
    check_no_branch();
  endtask

  task automatic test_invalid();
    check_invalid({6'b111111, 26'h2bcdef});
    check_invalid({`MIPS_OP_SPECIAL, 5'd1, 5'd2, 5'd3, 5'd0, 6'b111111});
    check_invalid({`MIPS_OP_SPECIAL, 5'd1, 5'd2, 5'd3, 5'd4, `MIPS_FN_SLL}); // rs must be 0
    check_invalid({`MIPS_OP_REGIMM, 5'd1, 5'd17, 16'h0010});
    end_test("invalid words");
  endtask

  initial begin
    reset_i     = 1'b1;
    pc_i        = 32'h0040_0000;
    inst_i.raw  = '0;
    reg1_data_i = '0;
    reg2_data_i = '0;
    ex_wreg_i   = 1'b0;
    ex_wd_i     = '0;
    ex_wdata_i  = '0;
    mem_wreg_i  = 1'b0;
    mem_wd_i    = '0;
    mem_wdata_i = '0;
    test_start  = 0;
    test_reset();
    test_alu_decode();
    test_forwarding();
    test_branches();
    test_jumps();
    test_invalid();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+logic
logic/mips_pkg.sv
logic/inst_decoder.sv
logic/operand_select.sv
logic/branch_unit.sv
logic/id_stage.sv
test/id_stage_tb.sv

// File: Makefile
TOP := id_stage_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
